// File: common/acq_macros.svh
`ifndef ACQ_MACROS_SVH
`define ACQ_MACROS_SVH

// wide input beat from the ADC and narrow output word
`define ACQ_S_WIDTH     128
`define ACQ_M_WIDTH     64

// lane layout of one input beat
`define ACQ_LANES       8
`define ACQ_LANE_WIDTH  16

// sample resolution, sits in the low bits of each lane
`define ACQ_ADC_WIDTH   12

// free running beat counter used as timestamp
`define ACQ_TS_WIDTH    16

// record lengths in wide beats
`define ACQ_PRE_LEN     12
// trigger beat included
`define ACQ_POST_LEN    38

// percent of adc full scale
`define ACQ_THRESH_PCT  10

`endif

// File: common/acq_pkg.sv
`include "acq_macros.svh"

package acq_pkg;

    // ring buffer acquisition states
    typedef enum logic [1:0]
    {
        FILL,
        ARMED,
        POST,
        READOUT
    } acq_state_e;

    // which half of the wide beat is on the output
    typedef enum logic
    {
        LOW_HALF,
        HIGH_HALF
    } pack_phase_e;

    // one adc sample without lane padding
    typedef logic [`ACQ_ADC_WIDTH-1:0] sample_t;

    // trigger level in adc codes, 10 percent of 4096 gives 409
    localparam sample_t THRESHOLD =
        sample_t'((`ACQ_THRESH_PCT * (1 << `ACQ_ADC_WIDTH)) / 100);

endpackage

// File: common/beat_stream_if.sv
`timescale 1ns/1ps
`include "acq_macros.svh"

interface beat_stream_if;

    logic [`ACQ_S_WIDTH-1:0] data;
    logic                    valid;
    logic                    ready;
    // header beat of a record
    logic                    first;
    // final stored beat of a record
    logic                    last;

    // ring buffer side
    modport src
    (
        output data,
        output valid,
        output first,
        output last,
        input  ready
    );

    // packer side
    modport dst
    (
        input  data,
        input  valid,
        input  first,
        input  last,
        output ready
    );

endinterface

// File: common/sample_stream_if.sv
`timescale 1ns/1ps
`include "acq_macros.svh"

interface sample_stream_if;

    logic [`ACQ_S_WIDTH-1:0]  beat;
    logic                     valid;
    // beat has a lane at or above threshold
    logic                     trig;
    // beat count at the time of this beat
    logic [`ACQ_TS_WIDTH-1:0] ts;

    // input side, plain strobe without ready
    modport src
    (
        output beat,
        output valid,
        output trig,
        output ts
    );

    modport dst
    (
        input beat,
        input valid,
        input trig,
        input ts
    );

endinterface

// File: design/acq_frontend.sv
`timescale 1ns/1ps
`include "acq_macros.svh"

module acq_frontend
(
    input  logic                    AXIS_ACLK,
    input  logic                    AXIS_ARESETN,
    input  logic [`ACQ_S_WIDTH-1:0] s_axis_tdata,
    input  logic                    s_axis_tvalid,
    sample_stream_if.src            out
);

    logic [`ACQ_TS_WIDTH-1:0] beat_cnt;
    logic                     over_thresh;
    logic                     held_over;
    acq_pkg::sample_t         lane_sample [`ACQ_LANES];

    // any lane at or above the trigger level
    always_comb
    begin
        over_thresh = 1'b0;
        for (int i = 0; i < `ACQ_LANES; i++)
        begin
            lane_sample[i] = s_axis_tdata[i*`ACQ_LANE_WIDTH +: `ACQ_ADC_WIDTH];
            if (lane_sample[i] >= acq_pkg::THRESHOLD)
            begin
                over_thresh = 1'b1;
            end
        end
    end

    // same compare on the registered beat
    always_comb
    begin
        held_over = 1'b0;
        for (int i = 0; i < `ACQ_LANES; i++)
        begin
            if (out.beat[i*`ACQ_LANE_WIDTH +: `ACQ_ADC_WIDTH] >= acq_pkg::THRESHOLD)
            begin
                held_over = 1'b1;
            end
        end
    end

    // strobe, trigger flag and timestamp counter
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            out.valid <= 1'b0;
            out.trig  <= 1'b0;
            beat_cnt  <= '0;
        end
        else
        begin
            out.valid <= s_axis_tvalid;
            out.trig  <= s_axis_tvalid && over_thresh;
            // wraps at 2^16
            if (s_axis_tvalid)
            begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // beat and its count before the increment
    always_ff @(posedge AXIS_ACLK)
    begin
        if (s_axis_tvalid)
        begin
            out.beat <= s_axis_tdata;
            out.ts   <= beat_cnt;
        end
    end

    trig_matches_beat: assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        out.trig == (out.valid && held_over)
    ) else $error("trigger flag disagrees with the registered beat or its strobe");

endmodule

// File: design/acq_top.sv
`timescale 1ns/1ps
`include "acq_macros.svh"

module acq_top
(
    input  logic                    AXIS_ACLK,
    input  logic                    AXIS_ARESETN,

    // adc stream, cannot be stalled
    input  logic [`ACQ_S_WIDTH-1:0] s_axis_tdata,
    input  logic                    s_axis_tvalid,

    // record output
    output logic [`ACQ_M_WIDTH-1:0] m_axis_tdata,
    output logic                    m_axis_tvalid,
    input  logic                    m_axis_tready,
    output logic                    m_axis_tuser,
    output logic                    m_axis_tlast,

    // capture in progress
    output logic                    acq_busy
);

    sample_stream_if sample_if ();
    beat_stream_if   beat_if ();

    acq_frontend frontend_i
    (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .out           (sample_if.src)
    );

    acq_ring_buffer ring_buffer_i
    (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .in           (sample_if.dst),
        .out          (beat_if.src),
        .acq_busy     (acq_busy)
    );

    // 128 to 64 bit width converter
    stream_packer packer_i
    (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .in            (beat_if.dst),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tlast  (m_axis_tlast)
    );

endmodule

// File: design/stream_packer.sv
`timescale 1ns/1ps
`include "acq_macros.svh"

module stream_packer
(
    input  logic                    AXIS_ACLK,
    input  logic                    AXIS_ARESETN,
    beat_stream_if.dst              in,
    output logic [`ACQ_M_WIDTH-1:0] m_axis_tdata,
    output logic                    m_axis_tvalid,
    input  logic                    m_axis_tready,
    output logic                    m_axis_tuser,
    output logic                    m_axis_tlast
);

    logic [`ACQ_S_WIDTH-1:0] hold_beat;
    logic                    hold_first;
    logic                    hold_last;
    acq_pkg::pack_phase_e    phase;
    logic                    accept;
    logic                    word_done;

    // take a new wide beat only once both words are gone
    assign in.ready  = !m_axis_tvalid;
    assign accept    = in.valid && in.ready;
    assign word_done = m_axis_tvalid && m_axis_tready;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            m_axis_tvalid <= 1'b0;
            phase         <= acq_pkg::LOW_HALF;
            hold_first    <= 1'b0;
            hold_last     <= 1'b0;
        end
        else if (accept)
        begin
            m_axis_tvalid <= 1'b1;
            phase         <= acq_pkg::LOW_HALF;
            hold_first    <= in.first;
            hold_last     <= in.last;
        end
        else if (word_done)
        begin
            if (phase == acq_pkg::LOW_HALF)
            begin
                phase <= acq_pkg::HIGH_HALF;
            end
            else
            begin
                m_axis_tvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (accept)
        begin
            hold_beat <= in.data;
        end
    end

    // low half first
    assign m_axis_tdata = (phase == acq_pkg::LOW_HALF) ?
                          hold_beat[`ACQ_M_WIDTH-1:0] :
                          hold_beat[`ACQ_S_WIDTH-1:`ACQ_M_WIDTH];

    // frame marks only on the word they belong to
    assign m_axis_tuser = m_axis_tvalid && hold_first && (phase == acq_pkg::LOW_HALF);
    assign m_axis_tlast = m_axis_tvalid && hold_last && (phase == acq_pkg::HIGH_HALF);

    hold_word_on_stall: assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata) &&
            $stable(m_axis_tuser) && $stable(m_axis_tlast)
    ) else $error("output word changed while tready was low");

endmodule

// File: project.f
+incdir+common
common/acq_pkg.sv
common/sample_stream_if.sv
common/beat_stream_if.sv
design/acq_frontend.sv
ring_buffer/acq_ring_buffer.sv
design/stream_packer.sv
design/acq_top.sv
test/acq_tb.sv

// File: ring_buffer/acq_ring_buffer.sv
`timescale 1ns/1ps
`include "acq_macros.svh"

module acq_ring_buffer
(
    input  logic         AXIS_ACLK,
    input  logic         AXIS_ARESETN,
    sample_stream_if.dst in,
    beat_stream_if.src   out,
    output logic         acq_busy
);

    localparam int DEPTH   = `ACQ_PRE_LEN + `ACQ_POST_LEN;
    localparam int PTR_W   = $clog2(DEPTH);
    localparam int HIST_W  = $clog2(`ACQ_PRE_LEN);
    localparam int POST_W  = $clog2(`ACQ_POST_LEN);
    localparam int RD_W    = $clog2(DEPTH + 1);

    localparam logic [PTR_W-1:0]  PTR_LAST  = PTR_W'(DEPTH - 1);
    localparam logic [HIST_W-1:0] HIST_LAST = HIST_W'(`ACQ_PRE_LEN - 1);
    // trigger beat is taken in ARMED, the rest in POST
    localparam logic [POST_W-1:0] POST_LAST = POST_W'(`ACQ_POST_LEN - 2);
    // index 0 is the header, then DEPTH stored beats
    localparam logic [RD_W-1:0]   RD_LAST   = RD_W'(DEPTH);

    acq_pkg::acq_state_e state;

    logic [`ACQ_S_WIDTH-1:0]  mem [DEPTH];
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         wr_nxt;
    logic [PTR_W-1:0]         rd_ptr;
    logic [PTR_W-1:0]         rd_nxt;
    logic [HIST_W-1:0]        hist_cnt;
    logic [POST_W-1:0]        post_cnt;
    logic [RD_W-1:0]          rd_cnt;
    logic [`ACQ_TS_WIDTH-1:0] trig_ts;
    logic [`ACQ_S_WIDTH-1:0]  header_beat;
    logic                     wr_en;
    logic                     trig_hit;
    logic                     xfer;
    // last beat handed to the packer with its words still going out
    logic                     drain;

    assign wr_nxt   = (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
    assign rd_nxt   = (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;

    // input beats are dropped during readout
    assign wr_en    = in.valid && (state != acq_pkg::READOUT);
    assign trig_hit = (state == acq_pkg::ARMED) && in.valid && in.trig;
    assign xfer     = out.valid && out.ready;

    assign header_beat = {{(`ACQ_S_WIDTH - `ACQ_TS_WIDTH){1'b0}}, trig_ts};

    always_ff @(posedge AXIS_ACLK)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= in.beat;
        end
        if (trig_hit)
        begin
            trig_ts <= in.ts;
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            state    <= acq_pkg::FILL;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            hist_cnt <= '0;
            post_cnt <= '0;
            rd_cnt   <= '0;
            drain    <= 1'b0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= wr_nxt;
            end
            // packer ready again means the tlast word has left
            if (drain && out.ready)
            begin
                drain <= 1'b0;
            end
            case (state)
                acq_pkg::FILL:
                begin
                    if (in.valid)
                    begin
                        if (hist_cnt == HIST_LAST)
                        begin
                            state <= acq_pkg::ARMED;
                        end
                        else
                        begin
                            hist_cnt <= hist_cnt + 1'b1;
                        end
                    end
                end
                acq_pkg::ARMED:
                begin
                    if (trig_hit)
                    begin
                        state    <= acq_pkg::POST;
                        post_cnt <= '0;
                    end
                end
                acq_pkg::POST:
                begin
                    if (in.valid)
                    begin
                        if (post_cnt == POST_LAST)
                        begin
                            // oldest pre-trigger beat sits at the next write slot
                            state  <= acq_pkg::READOUT;
                            rd_ptr <= wr_nxt;
                            rd_cnt <= '0;
                        end
                        else
                        begin
                            post_cnt <= post_cnt + 1'b1;
                        end
                    end
                end
                acq_pkg::READOUT:
                begin
                    if (xfer)
                    begin
                        if (rd_cnt == RD_LAST)
                        begin
                            state    <= acq_pkg::FILL;
                            hist_cnt <= '0;
                            drain    <= 1'b1;
                        end
                        else
                        begin
                            rd_cnt <= rd_cnt + 1'b1;
                            // header does not consume a memory slot
                            if (rd_cnt != '0)
                            begin
                                rd_ptr <= rd_nxt;
                            end
                        end
                    end
                end
                default:
                begin
                    state <= acq_pkg::FILL;
                end
            endcase
        end
    end

    assign out.valid = (state == acq_pkg::READOUT);
    assign out.first = out.valid && (rd_cnt == '0);
    assign out.last  = out.valid && (rd_cnt == RD_LAST);
    assign out.data  = (rd_cnt == '0) ? header_beat : mem[rd_ptr];

    assign acq_busy  = trig_hit || (state == acq_pkg::POST) ||
                       (state == acq_pkg::READOUT) || drain;

    no_write_in_readout: assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        (state == acq_pkg::READOUT) |=> $stable(wr_ptr)
    ) else $error("history memory written during readout");

    hold_beat_on_stall: assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        out.valid && !out.ready |=> out.valid && $stable(out.data) &&
            $stable(out.first) && $stable(out.last)
    ) else $error("record beat changed while stalled");

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module acq_tb -f project.f -o acq_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/acq_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
    exit 0
fi
exit 1

// File: test/acq_tb.sv
`timescale 1ns/1ps
`include "acq_macros.svh"

module acq_tb;

    localparam int FULL_SCALE = 1 << `ACQ_ADC_WIDTH;
    localparam int THRESH     = (`ACQ_THRESH_PCT * FULL_SCALE) / 100;
    localparam int REC_WORDS  = 2 * (1 + `ACQ_PRE_LEN + `ACQ_POST_LEN);
    localparam int REC_LIMIT  = 6000;
    localparam int IDLE_LIMIT = 8;

    typedef logic [`ACQ_ADC_WIDTH-1:0] code_t;

    logic                    AXIS_ACLK;
    logic                    AXIS_ARESETN;
    logic [`ACQ_S_WIDTH-1:0] s_axis_tdata;
    logic                    s_axis_tvalid;
    logic [`ACQ_M_WIDTH-1:0] m_axis_tdata;
    logic                    m_axis_tvalid;
    logic                    m_axis_tready;
    logic                    m_axis_tuser;
    logic                    m_axis_tlast;
    logic                    acq_busy;

    logic [31:0] lfsr;
    int          ready_mode;
    string       test_name;

    // reference model of the capture rules
    logic [`ACQ_TS_WIDTH-1:0] beat_count;
    logic [`ACQ_TS_WIDTH-1:0] trig_ts;
    logic [`ACQ_S_WIDTH-1:0]  hist_q [$];
    logic [`ACQ_S_WIDTH-1:0]  post_q [$];
    logic                     in_post;
    logic                     rec_waiting;

    // predicted output words, one name per record
    logic [`ACQ_M_WIDTH-1:0]  exp_words [$];
    string                    rec_names [$];
    int                       word_idx;
    int                       records_done;
    int                       records_made;

    logic                     was_stalled;
    logic [`ACQ_M_WIDTH-1:0]  held_data;
    logic                     held_user;
    logic                     held_last;

    int mismatch_errors;
    int other_errors;

    acq_top dut_i
    (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tlast  (m_axis_tlast),
        .acq_busy      (acq_busy)
    );

    initial
    begin
        AXIS_ACLK = 1'b0;
        forever #10 AXIS_ACLK = ~AXIS_ACLK;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic bit crosses_threshold(input logic [`ACQ_S_WIDTH-1:0] b);
        bit hit;
        hit = 1'b0;
        for (int i = 0; i < `ACQ_LANES; i++)
        begin
            if (int'(b[i*`ACQ_LANE_WIDTH +: `ACQ_ADC_WIDTH]) >= THRESH)
            begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // all lanes below the trigger level
    function automatic logic [`ACQ_S_WIDTH-1:0] quiet_beat();
        logic [`ACQ_S_WIDTH-1:0] b;
        b = '0;
        for (int i = 0; i < `ACQ_LANES; i++)
        begin
            b[i*`ACQ_LANE_WIDTH +: `ACQ_ADC_WIDTH] = code_t'(rand_bits(12) % THRESH);
        end
        return b;
    endfunction

    // one random lane at or above the trigger level
    function automatic logic [`ACQ_S_WIDTH-1:0] hot_beat();
        logic [`ACQ_S_WIDTH-1:0] b;
        int                      lane;
        b = quiet_beat();
        lane = int'(rand_bits(3));
        b[lane*`ACQ_LANE_WIDTH +: `ACQ_ADC_WIDTH] =
            code_t'(THRESH + (rand_bits(12) % (FULL_SCALE - THRESH)));
        return b;
    endfunction

    function automatic logic [`ACQ_S_WIDTH-1:0] any_beat();
        logic [`ACQ_S_WIDTH-1:0] b;
        b = '0;
        for (int i = 0; i < `ACQ_LANES; i++)
        begin
            b[i*`ACQ_LANE_WIDTH +: `ACQ_ADC_WIDTH] = code_t'(rand_bits(12));
        end
        return b;
    endfunction

    // header, then pre-trigger history, then post beats, low half first
    task automatic build_record();
        exp_words.push_back({{(`ACQ_M_WIDTH - `ACQ_TS_WIDTH){1'b0}}, trig_ts});
        exp_words.push_back({`ACQ_M_WIDTH{1'b0}});
        foreach (hist_q[i])
        begin
            exp_words.push_back(hist_q[i][`ACQ_M_WIDTH-1:0]);
            exp_words.push_back(hist_q[i][`ACQ_S_WIDTH-1:`ACQ_M_WIDTH]);
        end
        foreach (post_q[i])
        begin
            exp_words.push_back(post_q[i][`ACQ_M_WIDTH-1:0]);
            exp_words.push_back(post_q[i][`ACQ_S_WIDTH-1:`ACQ_M_WIDTH]);
        end
        rec_names.push_back(test_name);
        records_made++;
    endtask

    task automatic model_beat(input logic [`ACQ_S_WIDTH-1:0] b);
        logic [`ACQ_TS_WIDTH-1:0] ts;
        ts = beat_count;
        beat_count = beat_count + 1'b1;
        // beats during readout are counted but not stored
        if (!rec_waiting)
        begin
            if (in_post)
            begin
                post_q.push_back(b);
                if (post_q.size() == `ACQ_POST_LEN)
                begin
                    build_record();
                    in_post = 1'b0;
                    rec_waiting = 1'b1;
                end
            end
            else if (hist_q.size() == `ACQ_PRE_LEN && crosses_threshold(b))
            begin
                trig_ts = ts;
                post_q.delete();
                post_q.push_back(b);
                in_post = 1'b1;
            end
            else
            begin
                hist_q.push_back(b);
                if (hist_q.size() > `ACQ_PRE_LEN)
                begin
                    void'(hist_q.pop_front());
                end
            end
        end
    endtask

    // history must refill after each record
    task automatic model_rearm();
        rec_waiting = 1'b0;
        hist_q.delete();
    endtask

    task automatic check_hold();
        if (!m_axis_tvalid)
        begin
            other_errors++;
            $display("tvalid dropped while tready was low in %s", test_name);
        end
        else
        begin
            if (m_axis_tdata !== held_data)
            begin
                mismatch_errors++;
                $display("Mismatch %s held tdata: expected %h, actual %h",
                         test_name, held_data, m_axis_tdata);
            end
            if (m_axis_tuser !== held_user || m_axis_tlast !== held_last)
            begin
                mismatch_errors++;
                $display("Mismatch %s held tuser/tlast: expected %b%b, actual %b%b",
                         test_name, held_user, held_last, m_axis_tuser, m_axis_tlast);
            end
        end
    endtask

    // word that transfers on the coming rising edge
    task automatic take_word();
        logic [`ACQ_M_WIDTH-1:0] want;
        if (exp_words.size() == 0)
        begin
            other_errors++;
            $display("Output word %h arrived while no record was expected", m_axis_tdata);
        end
        else
        begin
            want = exp_words.pop_front();
            if (m_axis_tdata !== want)
            begin
                mismatch_errors++;
                $display("Mismatch %s word %0d tdata: expected %h, actual %h",
                         rec_names[0], word_idx, want, m_axis_tdata);
            end
            if (m_axis_tuser !== (word_idx == 0))
            begin
                mismatch_errors++;
                $display("Mismatch %s word %0d tuser: expected %0b, actual %0b",
                         rec_names[0], word_idx, word_idx == 0, m_axis_tuser);
            end
            if (m_axis_tlast !== (word_idx == REC_WORDS - 1))
            begin
                mismatch_errors++;
                $display("Mismatch %s word %0d tlast: expected %0b, actual %0b",
                         rec_names[0], word_idx, word_idx == REC_WORDS - 1, m_axis_tlast);
            end
            if (acq_busy !== 1'b1)
            begin
                other_errors++;
                $display("acq_busy was low while word %0d of %s went out",
                         word_idx, rec_names[0]);
            end
            word_idx++;
            if (word_idx == REC_WORDS)
            begin
                word_idx = 0;
                void'(rec_names.pop_front());
                records_done++;
            end
        end
    endtask

    // one clock on the falling edge, output side first
    task automatic tick();
        logic ready_now;
        @(negedge AXIS_ACLK);
        if (was_stalled)
        begin
            check_hold();
        end
        case (ready_mode)
            0:       ready_now = 1'b1;
            1:       ready_now = (rand_bits(2) != 32'd0);
            default: ready_now = (rand_bits(2) == 32'd0);
        endcase
        m_axis_tready = ready_now;
        if (m_axis_tvalid && ready_now)
        begin
            take_word();
        end
        was_stalled = m_axis_tvalid && !ready_now;
        held_data = m_axis_tdata;
        held_user = m_axis_tuser;
        held_last = m_axis_tlast;
        s_axis_tvalid = 1'b0;
    endtask

    task automatic send_beat(input logic [`ACQ_S_WIDTH-1:0] b, input bit gaps);
        if (gaps)
        begin
            if (rand_bits(3) == 32'd0)
            begin
                tick();
            end
        end
        tick();
        s_axis_tdata = b;
        s_axis_tvalid = 1'b1;
        model_beat(b);
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout in %s: %s", test_name, what);
        $display("mismatches: %0d, other errors: %0d", mismatch_errors, other_errors);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic wait_record(input int target);
        int cycles;
        cycles = 0;
        while (records_done < target && cycles < REC_LIMIT)
        begin
            tick();
            cycles++;
        end
        if (records_done < target)
        begin
            stop_on_timeout("the expected record did not finish on the output");
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (acq_busy !== 1'b0 && cycles < IDLE_LIMIT)
        begin
            tick();
            cycles++;
        end
        if (acq_busy !== 1'b0)
        begin
            stop_on_timeout("acq_busy stayed high after the record ended");
        end
    endtask

    // history fill, trigger beat, post beats, then drain the record
    task automatic run_phase(input string name, input int fill_len, input bit disarm,
                             input bit gaps, input int mode);
        int hot_idx;
        test_name = name;
        ready_mode = mode;
        hot_idx = -1;
        if (disarm)
        begin
            hot_idx = int'(rand_bits(4) % 12);
        end
        for (int i = 0; i < fill_len; i++)
        begin
            if (i == hot_idx)
            begin
                send_beat(hot_beat(), gaps);
            end
            else
            begin
                send_beat(quiet_beat(), gaps);
            end
        end
        send_beat(hot_beat(), gaps);
        for (int i = 1; i < `ACQ_POST_LEN; i++)
        begin
            send_beat(any_beat(), gaps);
        end
        wait_record(records_made);
        wait_idle();
        model_rearm();
    endtask

    initial
    begin
        AXIS_ARESETN = 1'b0;
        s_axis_tdata = '0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b0;
        lfsr = 32'hf7e4;
        ready_mode = 0;
        test_name = "reset";
        beat_count = '0;
        trig_ts = '0;
        in_post = 1'b0;
        rec_waiting = 1'b0;
        word_idx = 0;
        records_done = 0;
        records_made = 0;
        was_stalled = 1'b0;
        held_data = '0;
        held_user = 1'b0;
        held_last = 1'b0;
        mismatch_errors = 0;
        other_errors = 0;

        repeat (4) tick();
        AXIS_ARESETN = 1'b1;
        tick();
        if (acq_busy !== 1'b0 || m_axis_tvalid !== 1'b0 ||
            m_axis_tuser !== 1'b0 || m_axis_tlast !== 1'b0)
        begin
            other_errors++;
            $display("Outputs or acq_busy were not low after reset");
        end

        run_phase("basic", 12, 1'b0, 1'b0, 0);
        run_phase("gaps", 12 + int'(rand_bits(4)), 1'b0, 1'b1, 1);
        for (int k = 0; k < 3; k++)
        begin
            run_phase("disarm", 12 + int'(rand_bits(3)), 1'b1, 1'b1, 1);
        end
        run_phase("stall", 16, 1'b1, 1'b1, 2);
        // more than 2^16 beats so the timestamp wraps
        run_phase("wrap", 66000, 1'b0, 1'b0, 1);
        run_phase("after_wrap", 12, 1'b1, 1'b1, 2);

        repeat (20) tick();
        if (exp_words.size() != 0)
        begin
            other_errors++;
            $display("%0d predicted output words never appeared", exp_words.size());
        end

        $display("mismatches: %0d, other errors: %0d", mismatch_errors, other_errors);
        if (mismatch_errors + other_errors == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
